/* Bender.yml */
package:
  name: mipsCore

sources:
  - files:
      - common/mipsPkg.sv
      - decoder/instrDecoder.sv
      - logic/regFile.sv
      - logic/aluUnit.sv
      - logic/nextPc.sv
      - logic/mipsCore.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mipsCoreTb.sv

/* common/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    // ####################################################################
    // Primary opcodes
    // ####################################################################

    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBgtz    = 6'b000111;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLb      = 6'b100000;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;

    // ####################################################################
    // Function codes of opSpecial
    // ####################################################################

    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnJalr = 6'b001001;
    localparam logic [5:0] fnAdd  = 6'b100000;
    localparam logic [5:0] fnSub  = 6'b100010;
    localparam logic [5:0] fnXor  = 6'b100110;

    localparam logic [31:0] resetPc = 32'h0000_3000;  // First fetch after reset

    // ####################################################################
    // Control encodings
    // ####################################################################

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluOr, aluXor, aluSll
    } aluOp_t;

    typedef enum logic [1:0] {
        extZero, extSign, extUpper  // Upper puts imm16 in bits 31:16
    } extOp_t;

    typedef enum logic [1:0] {
        wbAlu, wbWord, wbByte, wbLink
    } wbSel_t;

    typedef enum logic [2:0] {
        npcSeq, npcBeq, npcBgtz, npcJump, npcReg
    } npcOp_t;

    typedef struct packed {
        aluOp_t     aluOp;
        extOp_t     extOp;
        wbSel_t     wbSel;
        npcOp_t     npcOp;
        logic       aluSrc;    // Second ALU operand is the extended immediate
        logic       shiftOp;   // Shift amount comes from the shamt field
        logic       regWrite;
        logic [4:0] destReg;
        logic       memWrite;
        logic       memRead;
    } ctrl_t;

endpackage

`default_nettype wire

/* decoder/instrDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
    input  wire logic [31:0]    instr,
    output logic [4:0]          rs,
    output logic [4:0]          rt,
    output logic [4:0]          shamt,
    output logic [15:0]         imm16,
    output logic [25:0]         imm26,
    output mipsPkg::ctrl_t      ctrl
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rd;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];
    assign imm26  = instr[25:0];

    always_comb begin
        ctrl = '0;  // Anything unrecognised falls through as a no-op
        case (opcode)
            opSpecial: begin
                case (funct)
                    fnAdd: begin
                        ctrl.aluOp    = aluAdd;
                        ctrl.regWrite = 1'b1;
                        ctrl.destReg  = rd;
                    end
                    fnSub: begin
                        ctrl.aluOp    = aluSub;
                        ctrl.regWrite = 1'b1;
                        ctrl.destReg  = rd;
                    end
                    fnXor: begin
                        ctrl.aluOp    = aluXor;
                        ctrl.regWrite = 1'b1;
                        ctrl.destReg  = rd;
                    end
                    fnSll: begin
                        ctrl.aluOp    = aluSll;
                        ctrl.shiftOp  = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.destReg  = rd;
                    end
                    fnJr: begin
                        ctrl.npcOp = npcReg;
                    end
                    fnJalr: begin
                        ctrl.npcOp    = npcReg;
                        ctrl.wbSel    = wbLink;
                        ctrl.regWrite = 1'b1;
                        ctrl.destReg  = rd;
                    end
                    default: ;
                endcase
            end
            opOri: begin
                ctrl.aluOp    = aluOr;
                ctrl.extOp    = extZero;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rt;
            end
            opAddi: begin
                ctrl.extOp    = extSign;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rt;
            end
            opLui: begin
                ctrl.aluOp    = aluSll;  // Zero shift passes the upper immediate
                ctrl.extOp    = extUpper;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rt;
            end
            opLw, opLb: begin
                ctrl.extOp    = extSign;
                ctrl.aluSrc   = 1'b1;
                ctrl.wbSel    = (opcode == opLw) ? wbWord : wbByte;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rt;
            end
            opSw: begin
                ctrl.extOp    = extSign;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq: begin
                ctrl.extOp = extSign;
                ctrl.npcOp = npcBeq;
            end
            opBgtz: begin
                ctrl.extOp = extSign;
                ctrl.npcOp = npcBgtz;
            end
            opJ: begin
                ctrl.npcOp = npcJump;
            end
            opJal: begin
                ctrl.npcOp    = npcJump;
                ctrl.wbSel    = wbLink;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = 5'd31;
            end
            default: ;
        endcase
        if (ctrl.destReg == 5'd0) begin
            ctrl.regWrite = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/aluUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
    input  wire mipsPkg::aluOp_t    aluOp,
    input  wire logic [31:0]        operandA,
    input  wire logic [31:0]        operandB,
    input  wire logic [4:0]         shamt,
    input  wire logic               shiftOp,
    output logic [31:0]             result,
    output logic                    equal,
    output logic                    positive
);
    import mipsPkg::*;

    logic [4:0] shiftAmount;

    // lui runs through the shifter with a zero amount
    assign shiftAmount = shiftOp ? shamt : 5'd0;

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = operandA + operandB;  // Wraps, no overflow trap
            end
            aluSub: begin
                result = operandA - operandB;
            end
            aluOr: begin
                result = operandA | operandB;
            end
            aluXor: begin
                result = operandA ^ operandB;
            end
            aluSll: begin
                result = operandB << shiftAmount;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign equal    = (operandA == operandB);
    assign positive = !operandA[31] && (operandA != '0);  // Signed compare against zero

endmodule

`default_nettype wire

/* logic/mipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore (
    input  wire logic           clk,
    input  wire logic           reset,
    output logic [31:0]         pc,
    input  wire logic [31:0]    instr,
    output logic [31:0]         dataAddr,
    output logic [31:0]         writeData,
    output logic                memWrite,
    input  wire logic [31:0]    readData,
    output logic                regWriteEn,
    output logic [4:0]          regWriteAddr,
    output logic [31:0]         regWriteData
);
    import mipsPkg::*;

    ctrl_t       ctrl;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    logic [25:0] imm26;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] extImm;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic        equal;
    logic        positive;
    logic [31:0] linkAddr;
    logic [31:0] loadWord;
    logic [7:0]  loadByte;

    // ####################################################################
    // Decode and operands
    // ####################################################################

    instrDecoder decoder (
        .instr(instr), .rs(rs), .rt(rt), .shamt(shamt),
        .imm16(imm16), .imm26(imm26), .ctrl(ctrl)
    );

    regFile registers (
        .clk(clk), .reset(reset),
        .readAddrA(rs), .readAddrB(rt),
        .readDataA(rsData), .readDataB(rtData),
        .writeEn(regWriteEn), .writeAddr(regWriteAddr), .writeData(regWriteData)
    );

    always_comb begin
        case (ctrl.extOp)
            extSign:  extImm = {{16{imm16[15]}}, imm16};
            extUpper: extImm = {imm16, 16'h0000};
            default:  extImm = {16'h0000, imm16};
        endcase
    end

    assign aluB = ctrl.aluSrc ? extImm : rtData;

    // ####################################################################
    // Execute and next pc
    // ####################################################################

    aluUnit alu (
        .aluOp(ctrl.aluOp), .operandA(rsData), .operandB(aluB),
        .shamt(shamt), .shiftOp(ctrl.shiftOp),
        .result(aluResult), .equal(equal), .positive(positive)
    );

    nextPc pcUnit (
        .clk(clk), .reset(reset), .npcOp(ctrl.npcOp),
        .equal(equal), .positive(positive),
        .imm16(imm16), .imm26(imm26), .regTarget(rsData),
        .pc(pc), .linkAddr(linkAddr)
    );

    // ####################################################################
    // Memory access and writeback
    // ####################################################################

    assign dataAddr  = aluResult;
    assign writeData = rtData;
    assign memWrite  = ctrl.memWrite & ~reset;

    assign loadWord = ctrl.memRead ? readData : '0;  // Quiet unless a load is decoded

    always_comb begin
        case (dataAddr[1:0])  // Little-endian byte lanes
            2'd0:    loadByte = loadWord[7:0];
            2'd1:    loadByte = loadWord[15:8];
            2'd2:    loadByte = loadWord[23:16];
            default: loadByte = loadWord[31:24];
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            wbWord:  regWriteData = loadWord;
            wbByte:  regWriteData = {{24{loadByte[7]}}, loadByte};
            wbLink:  regWriteData = linkAddr;
            default: regWriteData = aluResult;
        endcase
    end

    assign regWriteEn   = ctrl.regWrite & ~reset;
    assign regWriteAddr = ctrl.destReg;

endmodule

`default_nettype wire

/* logic/nextPc.sv */
`timescale 1ns/100ps
`default_nettype none

module nextPc (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire mipsPkg::npcOp_t    npcOp,
    input  wire logic               equal,
    input  wire logic               positive,
    input  wire logic [15:0]        imm16,
    input  wire logic [25:0]        imm26,
    input  wire logic [31:0]        regTarget,
    output logic [31:0]             pc,
    output logic [31:0]             linkAddr
);
    import mipsPkg::*;

    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] pcNext;

    assign pcPlus4      = pc + 32'd4;
    assign linkAddr     = pcPlus4;  // No delay slot, so the link is the next word
    assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], imm26, 2'b00};

    always_comb begin
        case (npcOp)
            npcBeq: begin
                pcNext = equal ? branchTarget : pcPlus4;
            end
            npcBgtz: begin
                pcNext = positive ? branchTarget : pcPlus4;
            end
            npcJump: begin
                pcNext = jumpTarget;
            end
            npcReg: begin
                pcNext = regTarget;
            end
            default: begin
                pcNext = pcPlus4;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic [4:0]     readAddrA,
    input  wire logic [4:0]     readAddrB,
    output logic [31:0]         readDataA,
    output logic [31:0]         readDataB,
    input  wire logic           writeEn,
    input  wire logic [4:0]     writeAddr,
    input  wire logic [31:0]    writeData
);

    logic [31:0] regs [31:1];  // No storage behind register 0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;  // Decoder never enables a write to 0
        end
    end

    always_comb begin
        if (readAddrA == 5'd0) begin
            readDataA = '0;
        end else begin
            readDataA = regs[readAddrA];
        end
    end

    always_comb begin
        if (readAddrB == 5'd0) begin
            readDataB = '0;
        end else begin
            readDataB = regs[readAddrB];
        end
    end

endmodule

`default_nettype wire

/* mipsCore.f */
+incdir+verification
common/mipsPkg.sv
decoder/instrDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/nextPc.sv
logic/mipsCore.sv
verification/mipsCoreTb.sv

/* verification/refModel.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

localparam int memWords = 256;  // 1 KB data array

// What the core should show on its ports while one instruction is fetched
typedef struct packed {
    logic        regWrite;
    logic [4:0]  regAddr;
    logic [31:0] regData;
    logic        store;
    logic [31:0] storeAddr;
    logic [31:0] storeData;
} predict_t;

logic [31:0] modelRegs [32];
logic [31:0] modelMem [memWords];
logic [31:0] modelPc;

function automatic logic [31:0] fillWord(input int unsigned index);
    return (index * 32'h9e37_79b1) ^ 32'h5a3c_c3a5;  // Odd multiplier keeps words distinct
endfunction

function automatic logic [31:0] signedByte(input logic [31:0] word, input logic [1:0] lane);
    logic [7:0] value;
    value = word[8 * lane +: 8];
    return {{24{value[7]}}, value};
endfunction

task automatic modelReset;
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    for (int i = 0; i < memWords; i++) begin
        modelMem[i] = fillWord(i);
    end
    modelPc = resetPc;
endtask

task automatic setWrite(inout predict_t p, input logic [4:0] dest, input logic [31:0] value);
    p.regWrite = (dest != 5'd0);  // Register 0 never takes a result
    p.regAddr  = dest;
    p.regData  = value;
endtask

// ####################################################################
// One instruction of the subset, no delay slot
// ####################################################################

task automatic modelStep(input logic [31:0] word, output predict_t prediction);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sImm;
    logic [31:0] addr;
    logic [31:0] seqPc;
    logic [31:0] next;
    a = modelRegs[word[25:21]];
    b = modelRegs[word[20:16]];
    sImm = {{16{word[15]}}, word[15:0]};
    addr = a + sImm;
    seqPc = modelPc + 32'd4;
    next = seqPc;
    prediction = '0;
    case (word[31:26])
        opSpecial: begin
            case (word[5:0])
                fnAdd:   setWrite(prediction, word[15:11], a + b);
                fnSub:   setWrite(prediction, word[15:11], a - b);
                fnXor:   setWrite(prediction, word[15:11], a ^ b);
                fnSll:   setWrite(prediction, word[15:11], b << word[10:6]);
                fnJr:    next = a;
                fnJalr: begin
                    next = a;
                    setWrite(prediction, word[15:11], seqPc);
                end
                default: ;
            endcase
        end
        opOri:   setWrite(prediction, word[20:16], a | {16'h0000, word[15:0]});
        opAddi:  setWrite(prediction, word[20:16], a + sImm);
        opLui:   setWrite(prediction, word[20:16], {word[15:0], 16'h0000});
        opLw:    setWrite(prediction, word[20:16], modelMem[addr[9:2]]);
        opLb:    setWrite(prediction, word[20:16], signedByte(modelMem[addr[9:2]], addr[1:0]));
        opSw: begin
            prediction.store     = 1'b1;
            prediction.storeAddr = addr;
            prediction.storeData = b;
            modelMem[addr[9:2]]  = b;
        end
        opBeq:   if (a == b) next = seqPc + (sImm << 2);
        opBgtz:  if ($signed(a) > 0) next = seqPc + (sImm << 2);
        opJ:     next = {seqPc[31:28], word[25:0], 2'b00};
        opJal: begin
            next = {seqPc[31:28], word[25:0], 2'b00};
            setWrite(prediction, 5'd31, seqPc);
        end
        default: ;
    endcase
    if (prediction.regWrite) modelRegs[prediction.regAddr] = prediction.regData;
    modelPc = next;
endtask

`endif

/* verification/mipsCoreTb.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCoreTb;
    import mipsPkg::*;

    `include "refModel.svh"

    localparam int          numTests    = 6;
    localparam int          progLen     = 60;
    localparam int          resetCycles = 8;
    localparam int          clkPeriod   = 40;
    localparam int          driveDelay  = 2;
    localparam int          cycleLimit  = numTests * progLen * 2 + numTests * (resetCycles + 2);
    localparam logic [4:0]  baseReg     = 5'd28;  // Holds the data base and is never a random target
    localparam logic [31:0] randomSeed  = 32'ha5f0_f84d;

    logic        clk;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] dataAddr;
    logic [31:0] writeData;
    logic        memWrite;
    logic [31:0] readData;
    logic        regWriteEn;
    logic [4:0]  regWriteAddr;
    logic [31:0] regWriteData;
    logic [31:0] instrMem [progLen];
    logic [31:0] dataMem [memWords];
    int          errorCount = 0;
    int          failedTests = 0;
    int          cycleCount = 0;

    mipsCore dut0 (
        .clk(clk), .reset(reset), .pc(pc), .instr(instr),
        .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite), .readData(readData),
        .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // ####################################################################
    // Memories answer in the same cycle
    // ####################################################################

    always_comb begin
        if (pc >= resetPc && pc < resetPc + 4 * progLen) instr = instrMem[(pc - resetPc) >> 2];
        else instr = '0;
    end

    assign readData = dataMem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (memWrite) dataMem[dataAddr[9:2]] <= writeData;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the program never reached its final loop",
                     cycleCount);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] rType(input logic [4:0] s, input logic [4:0] t,
                                          input logic [4:0] d, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {opSpecial, s, t, d, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] s,
                                          input logic [4:0] t, input logic [15:0] imm);
        return {op, s, t, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op, input int unsigned target);
        logic [31:0] addr;
        addr = resetPc + 4 * target;
        return {op, addr[27:2]};
    endfunction

    function automatic logic [4:0] pickReg(input int unsigned range);
        logic [31:0] r;
        r = $urandom % range;
        return r[4:0];
    endfunction

    function automatic logic [15:0] dataOffset(input logic aligned);
        logic [31:0] r;
        if (aligned) r = ($urandom % 128) * 4 - 256;
        else r = $urandom % 512 - 256;
        return r[15:0];  // Base 0x200 keeps every access inside the 1 KB array
    endfunction

    task automatic buildProgram;
        logic [31:0] kind;
        logic [31:0] reach;
        logic [31:0] hop;
        logic [4:0]  s;
        logic [4:0]  t;
        logic [4:0]  d;
        logic [15:0] imm;
        instrMem[0] = iType(opLui, 5'd0, baseReg, 16'h0000);
        instrMem[1] = iType(opOri, baseReg, baseReg, 16'h0200);
        instrMem[2] = jType(opJal, 5);  // Call whose jr returns to slot 3
        instrMem[3] = iType(opOri, 5'd0, 5'd6, 16'h301c);
        instrMem[4] = rType(5'd6, 5'd0, 5'd7, 5'd0, fnJalr);  // Goes on to slot 7 with the link in r7
        instrMem[5] = rType(5'd31, 5'd0, 5'd0, 5'd0, fnJr);
        instrMem[6] = '0;
        for (int k = 7; k < progLen - 1; k++) begin
            kind  = $urandom % 15;
            s     = pickReg(32);
            t     = pickReg(32);
            d     = pickReg(28);
            imm   = $urandom;
            reach = progLen - 2 - k;
            if (reach > 3) reach = 3;  // Short hops so most of the program runs
            hop = $urandom % (reach + 1);
            case (kind)
                0:  instrMem[k] = rType(s, t, d, 5'd0, fnAdd);
                1:  instrMem[k] = rType(s, t, d, 5'd0, fnSub);
                2:  instrMem[k] = rType(s, t, d, 5'd0, fnXor);
                3:  instrMem[k] = rType(s, t, d, imm[10:6], fnSll);
                4:  instrMem[k] = iType(opOri, s, d, imm);
                5:  instrMem[k] = iType(opAddi, s, d, imm);
                6:  instrMem[k] = iType(opLui, 5'd0, d, imm);
                7:  instrMem[k] = iType(opLw, baseReg, d, dataOffset(1'b1));
                8:  instrMem[k] = iType(opLb, baseReg, d, dataOffset(1'b0));
                9:  instrMem[k] = iType(opSw, baseReg, t, dataOffset(1'b1));
                10: instrMem[k] = iType(opBeq, s, imm[0] ? s : t, hop[15:0]);
                11: instrMem[k] = iType(opBgtz, s, 5'd0, hop[15:0]);
                12: instrMem[k] = jType(opJ, k + 1 + hop);
                13: instrMem[k] = jType(opJal, k + 1 + hop);
                default: instrMem[k] = {6'b111111, s, t, imm};  // Outside the subset
            endcase
        end
        instrMem[progLen - 1] = jType(opJ, progLen - 1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("ERROR at %0t ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
    endtask

    task automatic runTest(input int testNum);
        predict_t    prediction;
        logic [31:0] curPc;
        logic [31:0] firstWord;
        int          retired;
        int          errorsBefore;
        logic        done;
        errorsBefore = errorCount;
        retired = 0;
        done = 1'b0;
        @(posedge clk);
        #driveDelay reset = 1'b1;
        buildProgram();
        for (int i = 0; i < memWords; i++) begin
            dataMem[i] <= fillWord(i);
        end
        modelReset();
        firstWord = instrMem[0];
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
            // Every other reset cycle fetches a store that must stay gated
            #driveDelay instrMem[0] = (i % 2 == 0) ? iType(opSw, 5'd0, baseReg, 16'h0200)
                                                   : firstWord;
            @(negedge clk);
            if (pc !== resetPc) reportMismatch("pc", resetPc, pc);
            if (memWrite !== 1'b0) reportMismatch("memWrite", 32'd0, memWrite);
            if (regWriteEn !== 1'b0) reportMismatch("regWriteEn", 32'd0, regWriteEn);
        end
        @(posedge clk);
        #driveDelay reset = 1'b0;
        while (!done) begin
            @(negedge clk);
            curPc = modelPc;
            if (pc !== curPc) reportMismatch("pc", curPc, pc);
            modelStep(instrMem[(curPc - resetPc) >> 2], prediction);
            if (regWriteEn !== prediction.regWrite)
                reportMismatch("regWriteEn", prediction.regWrite, regWriteEn);
            if (prediction.regWrite && regWriteAddr !== prediction.regAddr)
                reportMismatch("regWriteAddr", prediction.regAddr, regWriteAddr);
            if (prediction.regWrite && regWriteData !== prediction.regData)
                reportMismatch("regWriteData", prediction.regData, regWriteData);
            if (memWrite !== prediction.store)
                reportMismatch("memWrite", prediction.store, memWrite);
            if (prediction.store && dataAddr !== prediction.storeAddr)
                reportMismatch("dataAddr", prediction.storeAddr, dataAddr);
            if (prediction.store && writeData !== prediction.storeData)
                reportMismatch("writeData", prediction.storeData, writeData);
            retired++;
            done = (curPc == resetPc + 4 * (progLen - 1));  // Reached the closing self jump
        end
        if (errorCount > errorsBefore) failedTests++;
        $display("Test %0d: %0d instructions retired, %0d mismatches", testNum, retired,
                 errorCount - errorsBefore);
    endtask

    initial begin
        reset = 1'b1;
        void'($urandom(randomSeed));
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("Tests run: %0d, tests failed: %0d, mismatches: %0d", numTests, failedTests,
                 errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
